//--- mips_pipe_defs.svh
/*
 * MIPS pipeline constants
 * widths, memory sizes, opcodes, funct codes and control-word bit positions
 */
`ifndef MIPS_PIPE_DEFS_SVH
`define MIPS_PIPE_DEFS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define RESET_PC    32'h0040_0000
`define IMEM_DEPTH  256
`define IMEM_ADDR_W 8
`define DMEM_DEPTH  256
`define DMEM_ADDR_W 8

`define OP_RTYPE    6'h00
`define OP_ADDI     6'h08
`define OP_LW       6'h23
`define OP_SW       6'h2b
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_J        6'h02

`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`define CTRL_W      11
`define CB_JUMP     10
`define CB_BRANCH   9
`define CB_MEMREAD  8
`define CB_MEMWRITE 7
`define CB_MEMTOREG 6
`define CB_ALUOP_HI 5
`define CB_ALUOP_LO 4
`define CB_ALUSRC   2    // bit 3 spare
`define CB_REGWRITE 1
`define CB_REGDST   0

`endif

//--- mips_pipe_pkg.sv
/*
 * MIPS pipeline types
 * plain vector typedefs and the ALU operation enum
 */
`include "mips_pipe_defs.svh"

package mips_pipe_pkg;

    typedef logic [`WORD_W-1:0]      word_t;
    typedef logic [`WORD_W-1:0]      instr_t;
    typedef logic [`REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;
    typedef logic [`CTRL_W-1:0]      ctrl_t;
    typedef logic [1:0]              fwd_sel_t;    // [1] rs, [0] rt
    typedef logic [1:0]              stall_cnt_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_ctl_t;

endpackage

//--- reg_file.sv
/*
 * register file
 * 32 x 32, two read ports, one write port, same-cycle write-through
 */
`timescale 1ns/1ps

module reg_file (
    input  logic                     SYS_clk,
    input  mips_pipe_pkg::reg_addr_t rs_addr,
    input  mips_pipe_pkg::reg_addr_t rt_addr,
    input  mips_pipe_pkg::reg_addr_t wr_addr,
    input  logic                     wr_en,
    input  mips_pipe_pkg::word_t     wr_data,
    output mips_pipe_pkg::word_t     rs_val,
    output mips_pipe_pkg::word_t     rt_val
);
    import mips_pipe_pkg::*;

    word_t regs [32];

    always_ff @(posedge SYS_clk)
    begin
        if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // writeback value is visible to decode in the same cycle
    assign rs_val = (rs_addr == '0) ? '0 :
                    (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_val = (rt_addr == '0) ? '0 :
                    (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

//--- fetch_stage.sv
/*
 * fetch stage
 * program counter, next-PC select and instruction memory with its load port
 */
`timescale 1ns/1ps
`include "mips_pipe_defs.svh"

module fetch_stage (
    input  logic                      SYS_clk,
    input  logic                      SYS_reset,
    input  logic                      stall,
    input  logic                      branch_taken,
    input  logic                      jump,
    input  mips_pipe_pkg::word_t      d_pc,
    input  mips_pipe_pkg::word_t      d_imm,
    input  mips_pipe_pkg::instr_t     d_instr,
    input  logic                      prog_we,
    input  mips_pipe_pkg::imem_addr_t prog_addr,
    input  mips_pipe_pkg::instr_t     prog_data,
    output mips_pipe_pkg::word_t      f_pc,
    output mips_pipe_pkg::instr_t     f_instr
);
    import mips_pipe_pkg::*;

    instr_t imem [`IMEM_DEPTH];
    word_t  pc_offset;
    word_t  pc_next;

    assign pc_offset = f_pc - `RESET_PC;    // imem starts at the reset vector
    assign f_instr   = imem[pc_offset[`IMEM_ADDR_W+1:2]];

    always_comb
    begin
        if (stall)
            pc_next = f_pc;                                  // hazard holds fetch
        else if (branch_taken)
            pc_next = d_pc + 32'd4 + (d_imm << 2);
        else if (jump)
            pc_next = {d_pc[31:28], d_instr[25:0], 2'b00};
        else
            pc_next = f_pc + 32'd4;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            f_pc <= `RESET_PC;
        else
            f_pc <= pc_next;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset && prog_we)   // program image only goes in under reset
            imem[prog_addr] <= prog_data;
    end

    assert property (@(posedge SYS_clk) $rose(prog_we) |-> SYS_reset)
        else $error("prog_we raised outside reset");

endmodule

//--- hazard_unit.sv
/*
 * hazard unit
 * decode-stage stall counter and memory-to-decode forwarding selects
 */
`timescale 1ns/1ps
`include "mips_pipe_defs.svh"

module hazard_unit (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  mips_pipe_pkg::instr_t   d_instr,
    input  mips_pipe_pkg::instr_t   ex_instr,
    input  mips_pipe_pkg::instr_t   mem_instr,
    output logic                    stall,
    output mips_pipe_pkg::fwd_sel_t fwd_sel
);
    import mips_pipe_pkg::*;

    stall_cnt_t cnt_q;        // cycles still owed after this one
    stall_cnt_t stall_cnt;
    stall_cnt_t stall_len;
    logic [5:0] d_op;
    reg_addr_t  d_rs;
    reg_addr_t  d_rt;
    reg_addr_t  ex_dest;
    reg_addr_t  mem_dest;
    logic       d_uses_rs;
    logic       d_uses_rt;
    logic       ex_hit;
    logic       mem_hit;
    logic       mem_is_alu;

    // register an instruction writes, zero when it writes none
    function automatic reg_addr_t dest_of(instr_t ins);
        case (ins[31:26])
            `OP_RTYPE:        dest_of = ins[15:11];
            `OP_ADDI, `OP_LW: dest_of = ins[20:16];
            default:          dest_of = '0;
        endcase
    endfunction

    assign d_op      = d_instr[31:26];
    assign d_rs      = d_instr[25:21];
    assign d_rt      = d_instr[20:16];
    assign d_uses_rt = (d_op == `OP_RTYPE) || (d_op == `OP_SW) ||
                       (d_op == `OP_BEQ) || (d_op == `OP_BNE);
    assign d_uses_rs = d_uses_rt || (d_op == `OP_ADDI) || (d_op == `OP_LW);

    assign ex_dest  = dest_of(ex_instr);
    assign mem_dest = dest_of(mem_instr);    // r0 and empty slots never match

    assign ex_hit  = (ex_dest != '0) && ((d_uses_rs && ex_dest == d_rs) ||
                                         (d_uses_rt && ex_dest == d_rt));
    assign mem_hit = (mem_dest != '0) && ((d_uses_rs && mem_dest == d_rs) ||
                                          (d_uses_rt && mem_dest == d_rt));

    always_comb
    begin
        if (ex_hit)
            stall_len = (ex_instr[31:26] == `OP_LW) ? 2'd2 : 2'd1;
        else if (mem_hit && mem_instr[31:26] == `OP_LW)
            stall_len = 2'd1;    // load data is not forwarded
        else
            stall_len = 2'd0;
    end

    assign stall_cnt = (cnt_q != '0) ? cnt_q : stall_len;
    assign stall     = (stall_cnt != '0);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            cnt_q <= '0;
        else if (stall)
            cnt_q <= stall_cnt - 2'd1;
        else
            cnt_q <= '0;
    end

    assign mem_is_alu = (mem_instr[31:26] == `OP_RTYPE) || (mem_instr[31:26] == `OP_ADDI);
    assign fwd_sel[1] = mem_is_alu && (mem_dest != '0) && d_uses_rs && (mem_dest == d_rs);
    assign fwd_sel[0] = mem_is_alu && (mem_dest != '0) && d_uses_rt && (mem_dest == d_rt);

    assert property (@(posedge SYS_clk) disable iff (SYS_reset) stall_cnt <= 2'd2)
        else $error("stall count above 2");

endmodule

//--- decode_stage.sv
/*
 * decode stage
 * decode register, control decode, operand forwarding and early branch resolve
 */
`timescale 1ns/1ps
`include "mips_pipe_defs.svh"

module decode_stage (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  mips_pipe_pkg::instr_t    f_instr,
    input  mips_pipe_pkg::word_t     f_pc,
    input  logic                     stall,
    input  mips_pipe_pkg::fwd_sel_t  fwd_sel,
    input  mips_pipe_pkg::word_t     mem_alu_result,
    input  logic                     wb_reg_write,
    input  mips_pipe_pkg::reg_addr_t wb_dest,
    input  mips_pipe_pkg::word_t     wb_data,
    output mips_pipe_pkg::instr_t    d_instr,
    output mips_pipe_pkg::word_t     d_pc,
    output mips_pipe_pkg::ctrl_t     d_ctrl,
    output mips_pipe_pkg::word_t     d_rs_val,
    output mips_pipe_pkg::word_t     d_rt_val,
    output mips_pipe_pkg::word_t     d_imm,
    output mips_pipe_pkg::reg_addr_t d_dest,
    output logic                     branch_taken,
    output logic                     jump
);
    import mips_pipe_pkg::*;

    logic [5:0] opcode;
    word_t      rf_rs;
    word_t      rf_rt;
    logic       ops_equal;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            d_instr <= '0;
            d_pc    <= '0;
        end
        else if (!stall)
        begin
            d_instr <= (branch_taken || jump) ? '0 : f_instr;    // squash the younger fetch
            d_pc    <= f_pc;
        end
    end

    assign opcode = d_instr[31:26];

    always_comb
    begin
        d_ctrl = '0;
        case (opcode)
            `OP_RTYPE:
            begin
                d_ctrl[`CB_REGDST]                = 1'b1;
                d_ctrl[`CB_REGWRITE]              = 1'b1;
                d_ctrl[`CB_ALUOP_HI:`CB_ALUOP_LO] = 2'b10;
            end
            `OP_ADDI:
            begin
                d_ctrl[`CB_ALUSRC]   = 1'b1;
                d_ctrl[`CB_REGWRITE] = 1'b1;
            end
            `OP_LW:
            begin
                d_ctrl[`CB_MEMREAD]  = 1'b1;
                d_ctrl[`CB_MEMTOREG] = 1'b1;
                d_ctrl[`CB_ALUSRC]   = 1'b1;
                d_ctrl[`CB_REGWRITE] = 1'b1;
            end
            `OP_SW:
            begin
                d_ctrl[`CB_MEMWRITE] = 1'b1;
                d_ctrl[`CB_ALUSRC]   = 1'b1;
            end
            `OP_BEQ, `OP_BNE:
            begin
                d_ctrl[`CB_BRANCH]                = 1'b1;
                d_ctrl[`CB_ALUOP_HI:`CB_ALUOP_LO] = 2'b01;
            end
            `OP_J:    d_ctrl[`CB_JUMP] = 1'b1;
            default:  d_ctrl = '0;    // unsupported opcode runs as a nop
        endcase
    end

    assign d_dest = d_ctrl[`CB_REGDST] ? d_instr[15:11] : d_instr[20:16];
    assign d_imm  = {{16{d_instr[15]}}, d_instr[15:0]};

    reg_file i_reg_file (
        .SYS_clk (SYS_clk),
        .rs_addr (d_instr[25:21]),
        .rt_addr (d_instr[20:16]),
        .wr_addr (wb_dest),
        .wr_en   (wb_reg_write),
        .wr_data (wb_data),
        .rs_val  (rf_rs),
        .rt_val  (rf_rt)
    );

    assign d_rs_val = fwd_sel[1] ? mem_alu_result : rf_rs;
    assign d_rt_val = fwd_sel[0] ? mem_alu_result : rf_rt;

    // compare on forwarded values so the branch resolves here
    assign ops_equal    = (d_rs_val == d_rt_val);
    assign branch_taken = d_ctrl[`CB_BRANCH] && ((opcode == `OP_BEQ) ? ops_equal : !ops_equal);
    assign jump         = d_ctrl[`CB_JUMP];

    assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        branch_taken |-> (opcode == `OP_BEQ || opcode == `OP_BNE))
        else $error("branch taken on a non-branch opcode");

endmodule

//--- execute_stage.sv
/*
 * execute stage
 * execute register, ALU control and ALU
 */
`timescale 1ns/1ps
`include "mips_pipe_defs.svh"

module execute_stage (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  logic                     stall,
    input  mips_pipe_pkg::instr_t    d_instr,
    input  mips_pipe_pkg::ctrl_t     d_ctrl,
    input  mips_pipe_pkg::word_t     d_rs_val,
    input  mips_pipe_pkg::word_t     d_rt_val,
    input  mips_pipe_pkg::word_t     d_imm,
    input  mips_pipe_pkg::reg_addr_t d_dest,
    output mips_pipe_pkg::instr_t    ex_instr,
    output mips_pipe_pkg::ctrl_t     ex_ctrl,
    output mips_pipe_pkg::word_t     ex_alu_result,
    output mips_pipe_pkg::word_t     ex_store_data,
    output mips_pipe_pkg::reg_addr_t ex_dest
);
    import mips_pipe_pkg::*;

    word_t    ex_rs_val;
    word_t    ex_imm;
    word_t    alu_b;
    alu_ctl_t alu_ctl;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)    // stall drops a bubble in here
        begin
            ex_instr <= '0;
            ex_ctrl  <= '0;
            ex_dest  <= '0;
        end
        else
        begin
            ex_instr <= d_instr;
            ex_ctrl  <= d_ctrl;
            ex_dest  <= d_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_rs_val     <= d_rs_val;
        ex_store_data <= d_rt_val;    // rt doubles as store data
        ex_imm        <= d_imm;
    end

    always_comb
    begin
        case (ex_ctrl[`CB_ALUOP_HI:`CB_ALUOP_LO])
            2'b01:   alu_ctl = ALU_SUB;
            2'b10:
            begin
                case (ex_instr[5:0])
                    `FN_ADD: alu_ctl = ALU_ADD;
                    `FN_SUB: alu_ctl = ALU_SUB;
                    `FN_AND: alu_ctl = ALU_AND;
                    `FN_OR:  alu_ctl = ALU_OR;
                    `FN_SLT: alu_ctl = ALU_SLT;
                    default: alu_ctl = ALU_ADD;    // nop and unknown funct
                endcase
            end
            default: alu_ctl = ALU_ADD;    // addi and address calc
        endcase
    end

    assign alu_b = ex_ctrl[`CB_ALUSRC] ? ex_imm : ex_store_data;

    always_comb
    begin
        case (alu_ctl)
            ALU_SUB: ex_alu_result = ex_rs_val - alu_b;
            ALU_AND: ex_alu_result = ex_rs_val & alu_b;
            ALU_OR:  ex_alu_result = ex_rs_val | alu_b;
            ALU_SLT: ex_alu_result = {31'd0, $signed(ex_rs_val) < $signed(alu_b)};
            default: ex_alu_result = ex_rs_val + alu_b;
        endcase
    end

    // a real R-type must decode to its own ALU op, never the fallback
    assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (ex_ctrl[`CB_ALUOP_HI:`CB_ALUOP_LO] == 2'b10 && ex_instr != '0) |->
            ex_instr[5:0] inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT})
        else $error("illegal ALU control for R-type funct");

endmodule

//--- mem_wb_stage.sv
/*
 * memory and writeback stages
 * data memory access, then the writeback register and result select
 */
`timescale 1ns/1ps
`include "mips_pipe_defs.svh"

module mem_wb_stage (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  mips_pipe_pkg::instr_t    ex_instr,
    input  mips_pipe_pkg::ctrl_t     ex_ctrl,
    input  mips_pipe_pkg::word_t     ex_alu_result,
    input  mips_pipe_pkg::word_t     ex_store_data,
    input  mips_pipe_pkg::reg_addr_t ex_dest,
    output mips_pipe_pkg::instr_t    mem_instr,
    output mips_pipe_pkg::word_t     mem_alu_result,
    output logic                     wb_reg_write,
    output mips_pipe_pkg::reg_addr_t wb_dest,
    output mips_pipe_pkg::word_t     wb_data
);
    import mips_pipe_pkg::*;

    ctrl_t                   mem_ctrl;
    word_t                   mem_store_data;
    reg_addr_t               mem_dest;
    word_t                   dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_W-1:0] dmem_idx;
    word_t                   load_data;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_instr <= '0;
            mem_ctrl  <= '0;
            mem_dest  <= '0;
        end
        else
        begin
            mem_instr <= ex_instr;
            mem_ctrl  <= ex_ctrl;
            mem_dest  <= ex_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu_result <= ex_alu_result;
        mem_store_data <= ex_store_data;
    end

    assign dmem_idx  = mem_alu_result[`DMEM_ADDR_W+1:2];    // word address, byte offset dropped
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge SYS_clk)
    begin
        if (mem_ctrl[`CB_MEMWRITE])
            dmem[dmem_idx] <= mem_store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_reg_write <= 1'b0;
            wb_dest      <= '0;
        end
        else
        begin
            wb_reg_write <= mem_ctrl[`CB_REGWRITE] && (mem_dest != '0);    // r0 never strobes
            wb_dest      <= mem_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_data <= mem_ctrl[`CB_MEMTOREG] ? load_data : mem_alu_result;
    end

    assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_ctrl[`CB_MEMREAD] && mem_ctrl[`CB_MEMWRITE]))
        else $error("data memory read and write together");

endmodule

//--- mips_pipe.sv
/*
 * five-stage MIPS subset pipeline, top level
 * connects fetch, hazard, decode, execute and memory/writeback
 */
`timescale 1ns/1ps

module mips_pipe (
    input  logic                      SYS_clk,
    input  logic                      SYS_reset,
    input  logic                      prog_we,
    input  mips_pipe_pkg::imem_addr_t prog_addr,
    input  mips_pipe_pkg::instr_t     prog_data,
    output logic                      wb_reg_write,
    output mips_pipe_pkg::reg_addr_t  wb_dest,
    output mips_pipe_pkg::word_t      wb_data
);
    // port names match across stages, so instances connect by name
    mips_pipe_pkg::word_t     f_pc;
    mips_pipe_pkg::instr_t    f_instr;
    mips_pipe_pkg::instr_t    d_instr;
    mips_pipe_pkg::word_t     d_pc;
    mips_pipe_pkg::ctrl_t     d_ctrl;
    mips_pipe_pkg::word_t     d_rs_val;
    mips_pipe_pkg::word_t     d_rt_val;
    mips_pipe_pkg::word_t     d_imm;
    mips_pipe_pkg::reg_addr_t d_dest;
    logic                     branch_taken;
    logic                     jump;
    logic                     stall;
    mips_pipe_pkg::fwd_sel_t  fwd_sel;
    mips_pipe_pkg::instr_t    ex_instr;
    mips_pipe_pkg::ctrl_t     ex_ctrl;
    mips_pipe_pkg::word_t     ex_alu_result;
    mips_pipe_pkg::word_t     ex_store_data;
    mips_pipe_pkg::reg_addr_t ex_dest;
    mips_pipe_pkg::instr_t    mem_instr;
    mips_pipe_pkg::word_t     mem_alu_result;

    fetch_stage i_fetch_stage (.*);

    hazard_unit i_hazard_unit (.*);

    decode_stage i_decode_stage (.*);

    execute_stage i_execute_stage (.*);

    mem_wb_stage i_mem_wb_stage (.*);

endmodule

//--- tb_mips_pipe.sv
/*
 * directed testbench for the five-stage MIPS pipeline
 * runs short programs against a sequential ISA model and checks every writeback
 */
`timescale 1ns/1ps
`include "mips_pipe_defs.svh"

module tb_mips_pipe;
    import mips_pipe_pkg::*;

    logic       SYS_clk;
    logic       SYS_reset;
    logic       prog_we;
    imem_addr_t prog_addr;
    instr_t     prog_data;
    logic       wb_reg_write;
    reg_addr_t  wb_dest;
    word_t      wb_data;

    instr_t      prog [$];        // program image of the current test
    reg_addr_t   exp_reg [$];     // expected writebacks in program order
    word_t       exp_val [$];
    word_t       mregs [32];      // model state persists like the DUT's
    word_t       mdmem [`DMEM_DEPTH];
    logic [31:0] rng_state = 32'd44735;
    int          err_cnt = 0;
    int          timeout_cnt = 0;

    mips_pipe i_mips_pipe (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .wb_reg_write (wb_reg_write),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data)
    );

    always #4 SYS_clk = ~SYS_clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic instr_t r_type(logic [5:0] fn, int rd, int rs, int rt);
        return {`OP_RTYPE, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd), 5'd0, fn};
    endfunction

    function automatic instr_t i_type(logic [5:0] op, int rt, int rs, int imm);
        return {op, reg_addr_t'(rs), reg_addr_t'(rt), 16'(imm)};
    endfunction

    function automatic instr_t j_type(int idx);
        word_t addr;
        addr = `RESET_PC + 32'(idx * 4);
        return {`OP_J, addr[27:2]};
    endfunction

    function automatic logic [5:0] funct_for(int sel);
        case (sel)
            1:       return `FN_ADD;
            2:       return `FN_SUB;
            3:       return `FN_AND;
            4:       return `FN_OR;
            default: return `FN_SLT;
        endcase
    endfunction

    task automatic emit(instr_t ins);
        prog.push_back(ins);
    endtask

    // jump to itself parks the pipeline after the last instruction
    task automatic emit_halt();
        emit(j_type(prog.size()));
    endtask

    task automatic compare_reg(reg_addr_t got, reg_addr_t exp, string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s wrote r%0d, expected r%0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_word(word_t got, word_t exp, string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s data %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // sequential ISA interpreter, one instruction per step
    task automatic model_program();
        int        pc_idx;
        int        next_idx;
        int        steps;
        instr_t    ins;
        word_t     a;
        word_t     b;
        word_t     simm;
        word_t     res;
        word_t     addr;
        reg_addr_t dst;
        logic      wr;
        exp_reg.delete();
        exp_val.delete();
        pc_idx = 0;
        steps  = 0;
        while (pc_idx >= 0 && pc_idx < prog.size() && steps < 2000)
        begin
            ins      = prog[pc_idx];
            a        = mregs[ins[25:21]];
            b        = mregs[ins[20:16]];
            simm     = {{16{ins[15]}}, ins[15:0]};
            dst      = ins[20:16];
            wr       = 1'b0;
            res      = '0;
            next_idx = pc_idx + 1;
            steps++;
            case (ins[31:26])
                `OP_RTYPE:
                begin
                    wr  = 1'b1;
                    dst = ins[15:11];
                    case (ins[5:0])
                        `FN_ADD: res = a + b;
                        `FN_SUB: res = a - b;
                        `FN_AND: res = a & b;
                        `FN_OR:  res = a | b;
                        default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                end
                `OP_ADDI:
                begin
                    wr  = 1'b1;
                    res = a + simm;
                end
                `OP_LW:
                begin
                    wr   = 1'b1;
                    addr = a + simm;
                    res  = mdmem[addr[9:2]];
                end
                `OP_SW:
                begin
                    addr = a + simm;
                    mdmem[addr[9:2]] = b;
                end
                `OP_BEQ: if (a == b) next_idx = pc_idx + 1 + int'($signed(ins[15:0]));
                `OP_BNE: if (a != b) next_idx = pc_idx + 1 + int'($signed(ins[15:0]));
                `OP_J:
                begin
                    addr = `RESET_PC + 32'(pc_idx * 4);
                    addr = {addr[31:28], ins[25:0], 2'b00};
                    next_idx = int'((addr - `RESET_PC) >> 2);
                    if (next_idx == pc_idx)
                        break;    // halt reached
                end
                default: ;
            endcase
            if (wr && dst != '0)
            begin
                mregs[dst] = res;
                exp_reg.push_back(dst);
                exp_val.push_back(res);
            end
            pc_idx = next_idx;
        end
    endtask

    task automatic load_program();
        int i;
        @(posedge SYS_clk);
        #1 SYS_reset = 1'b1;
        for (i = 0; i < prog.size(); i++)
        begin
            @(posedge SYS_clk);
            #1;
            prog_we   = 1'b1;
            prog_addr = imem_addr_t'(i);
            prog_data = prog[i];
        end
        @(posedge SYS_clk);
        #1 prog_we = 1'b0;
        for (i = 0; i < 16; i++)
            @(posedge SYS_clk);
        #1 SYS_reset = 1'b0;
    endtask

    task automatic collect_writebacks(string name);
        int idx;
        int cycles;
        idx    = 0;
        cycles = 0;
        while (idx < exp_reg.size() && cycles < 600)
        begin
            @(negedge SYS_clk);    // outputs settled mid-cycle
            cycles++;
            if (wb_reg_write)
            begin
                compare_reg(wb_dest, exp_reg[idx], $sformatf("%s writeback %0d", name, idx));
                compare_word(wb_data, exp_val[idx], $sformatf("%s writeback %0d", name, idx));
                idx++;
            end
        end
        if (idx < exp_reg.size())
        begin
            $display("timeout in %s: only %0d of %0d writebacks arrived",
                     name, idx, exp_reg.size());
            timeout_cnt++;
        end
        else
        begin
            for (cycles = 0; cycles < 20; cycles++)
            begin
                @(negedge SYS_clk);
                if (wb_reg_write)
                begin
                    $display("ERR %0t: %s extra writeback to r%0d", $time, name, wb_dest);
                    err_cnt++;
                end
            end
        end
    endtask

    task automatic run_test(string name);
        model_program();
        load_program();
        collect_writebacks(name);
    endtask

    task automatic dependent_alu_chain();
        prog.delete();
        emit(i_type(`OP_ADDI, 1, 0, 5));
        emit(i_type(`OP_ADDI, 2, 1, 7));    // execute-stage dependence
        emit(r_type(`FN_ADD, 3, 1, 2));
        emit(r_type(`FN_SUB, 4, 3, 1));
        emit(r_type(`FN_AND, 5, 4, 3));
        emit(r_type(`FN_OR, 6, 5, 2));
        emit(r_type(`FN_SLT, 7, 1, 6));
        emit(r_type(`FN_SLT, 8, 6, 1));
        emit(i_type(`OP_ADDI, 9, 0, -3));
        emit(r_type(`FN_SLT, 10, 9, 1));    // signed compare
        emit_halt();
        run_test("alu chain");
    endtask

    task automatic store_load_use();
        prog.delete();
        emit(i_type(`OP_ADDI, 1, 0, 'h40));
        emit(i_type(`OP_ADDI, 2, 0, 1234));
        emit(i_type(`OP_SW, 2, 1, 8));
        emit(i_type(`OP_LW, 3, 1, 8));
        emit(r_type(`FN_ADD, 4, 3, 2));      // load-use, two stall cycles
        emit(i_type(`OP_LW, 5, 1, 8));
        emit(i_type(`OP_ADDI, 6, 0, 1));
        emit(r_type(`FN_ADD, 7, 5, 6));      // load one slot back
        emit_halt();
        run_test("store load");
    endtask

    task automatic branch_paths();
        prog.delete();
        emit(i_type(`OP_ADDI, 1, 0, 3));
        emit(i_type(`OP_ADDI, 2, 0, 3));
        emit(i_type(`OP_BEQ, 2, 1, 1));      // taken
        emit(i_type(`OP_ADDI, 3, 0, 111));
        emit(i_type(`OP_ADDI, 4, 0, 44));
        emit(i_type(`OP_BNE, 2, 1, 1));      // not taken
        emit(i_type(`OP_ADDI, 5, 0, 55));
        emit(i_type(`OP_ADDI, 6, 0, 9));
        emit(i_type(`OP_BNE, 1, 6, 1));      // taken on a fresh register
        emit(i_type(`OP_ADDI, 7, 0, 77));
        emit(i_type(`OP_BEQ, 1, 6, 1));
        emit(i_type(`OP_ADDI, 8, 0, 88));
        emit(i_type(`OP_ADDI, 9, 0, 3));
        emit(i_type(`OP_ADDI, 10, 0, 0));
        emit(i_type(`OP_ADDI, 10, 10, 2));   // loop body
        emit(i_type(`OP_ADDI, 9, 9, -1));
        emit(i_type(`OP_BNE, 0, 9, -3));
        emit_halt();
        run_test("branches");
    endtask

    task automatic jump_over();
        prog.delete();
        emit(i_type(`OP_ADDI, 1, 0, 1));
        emit(j_type(4));
        emit(i_type(`OP_ADDI, 2, 0, 22));
        emit(i_type(`OP_ADDI, 3, 0, 33));
        emit(i_type(`OP_ADDI, 4, 0, 44));
        emit(i_type(`OP_ADDI, 5, 4, 1));
        emit_halt();
        run_test("jump");
    endtask

    task automatic random_alu_program();
        logic [31:0] r;
        int          k;
        int          sel;
        int          rd;
        int          rs;
        int          rt;
        prog.delete();
        for (k = 1; k <= 7; k++)
        begin
            r = next_random();
            emit(i_type(`OP_ADDI, k, 0, int'(r[15:0])));
        end
        for (k = 0; k < 33; k++)
        begin
            r   = next_random();
            sel = int'((r >> 8) % 32'd6);
            rd  = 1 + int'((r >> 12) % 32'd7);
            rs  = 1 + int'((r >> 16) % 32'd7);
            rt  = 1 + int'((r >> 20) % 32'd7);
            if (sel == 0)
                emit(i_type(`OP_ADDI, rd, rs, int'(r[15:0])));
            else
                emit(r_type(funct_for(sel), rd, rs, rt));
        end
        emit_halt();
        run_test("random program");
    endtask

    task automatic zero_register_writes();
        prog.delete();
        emit(i_type(`OP_ADDI, 0, 0, 55));
        emit(i_type(`OP_ADDI, 1, 0, 7));
        emit(r_type(`FN_ADD, 0, 1, 1));
        emit(r_type(`FN_ADD, 2, 0, 0));      // must read zero
        emit(i_type(`OP_ADDI, 3, 0, 9));
        emit(r_type(`FN_OR, 4, 0, 3));
        emit_halt();
        run_test("zero register");
    endtask

    initial
    begin
        SYS_clk   = 1'b0;
        SYS_reset = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        foreach (mregs[i])
            mregs[i] = '0;
        foreach (mdmem[i])
            mdmem[i] = '0;

        dependent_alu_chain();
        store_load_use();
        branch_paths();
        jump_over();
        random_alu_program();
        zero_register_writes();

        $display("error count: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- mips_pipe.f
+incdir+.
mips_pipe_pkg.sv
reg_file.sv
fetch_stage.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
mips_pipe.sv
tb_mips_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the pipeline testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mips_pipe -f mips_pipe.f -o sim_tb

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q "^TEST PASSED$"; then
    exit 0
else
    exit 1
fi
